// File: logic/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Word address width for 1024 words
`define MEM_ADDR_W 10

// Data word width
`define MEM_DATA_W 64

// Counted wait edges between capture and done
`define MEM_WAIT_CYCLES 3

`endif

// File: logic/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

   //////////////////////////////
   // Storage types
   //////////////////////////////

   typedef logic [`MEM_ADDR_W-1:0] addr_t;

   typedef logic [`MEM_DATA_W-1:0] word_t;

   //////////////////////////////
   // Access sequencer states
   //////////////////////////////

   // ISSUE is the cycle the RAM strobe is high, CAPTURE takes the read word
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      ISSUE   = 3'd1,
      CAPTURE = 3'd2,
      WAIT    = 3'd3,
      DONE    = 3'd4
   } seq_state_t;

endpackage

// File: logic/request_latch.sv
`timescale 1ns/1ps

module request_latch (
   input  logic            clk,
   input  logic            rst,
   input  logic            accept,
   input  logic            write,
   input  mem_pkg::addr_t  addr,
   input  mem_pkg::word_t  wdata,
   output logic            ram_en,
   output logic            ram_we,
   output mem_pkg::addr_t  ram_addr,
   output mem_pkg::word_t  ram_wdata,
   output logic            req_write
);

   logic           write_q;
   mem_pkg::addr_t addr_q;
   mem_pkg::word_t wdata_q;

   // Held request flag and the one-cycle RAM strobe
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         write_q <= 1'b0;
         ram_en  <= 1'b0;
      end else begin
         ram_en <= accept;
         if (accept) begin
            write_q <= write;
         end
      end
   end

   // Address and data stay put until the next accepted request
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= addr;
         wdata_q <= wdata;
      end
   end

   assign ram_we    = write_q;
   assign ram_addr  = addr_q;
   assign ram_wdata = wdata_q;
   assign req_write = write_q;

   // One RAM access per accepted request
   a_ram_en_single: assert property (@(posedge clk) disable iff (!rst)
      ram_en |=> !ram_en);

endmodule

// File: logic/access_sequencer.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module access_sequencer (
   input  logic            clk,
   input  logic            rst,
   input  logic            enable,
   input  logic            req_write,
   input  mem_pkg::word_t  ram_rdata,
   output logic            accept,
   output logic            busy,
   output logic            done,
   output mem_pkg::word_t  rdata
);

   localparam int CNT_W = $clog2(`MEM_WAIT_CYCLES + 1);

   mem_pkg::seq_state_t state;
   mem_pkg::seq_state_t state_nxt;
   logic [CNT_W-1:0]    cnt;
   logic                time_up;
   mem_pkg::word_t      hold_q;

   //////////////////////////////
   // State machine
   //////////////////////////////

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= mem_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign time_up = (cnt == CNT_W'(`MEM_WAIT_CYCLES));

   always_comb begin
      state_nxt = state;
      case (state)
         mem_pkg::IDLE: begin
            if (enable) begin
               state_nxt = mem_pkg::ISSUE;
            end
         end
         // RAM sees the strobe in this cycle
         mem_pkg::ISSUE:   state_nxt = mem_pkg::CAPTURE;
         mem_pkg::CAPTURE: state_nxt = mem_pkg::WAIT;
         mem_pkg::WAIT: begin
            if (time_up) begin
               state_nxt = mem_pkg::DONE;
            end
         end
         mem_pkg::DONE:    state_nxt = mem_pkg::IDLE;
         default:          state_nxt = mem_pkg::IDLE;
      endcase
   end

   // Wait counter, zero on entry to WAIT
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         cnt <= '0;
      end else if (state == mem_pkg::DONE) begin
         cnt <= '0;
      end else if (state == mem_pkg::WAIT && !time_up) begin
         cnt <= cnt + 1'b1;
      end
   end

   //////////////////////////////
   // Read hold and outputs
   //////////////////////////////

   // RAM output is valid in CAPTURE, one edge after the strobe
   always_ff @(posedge clk) begin
      if (state == mem_pkg::CAPTURE && !req_write) begin
         hold_q <= ram_rdata;
      end
   end

   assign accept = (state == mem_pkg::IDLE) && enable;
   assign busy   = (state != mem_pkg::IDLE);
   assign done   = (state == mem_pkg::DONE);
   assign rdata  = (done && !req_write) ? hold_q : '0;

   a_done_single: assert property (@(posedge clk) disable iff (!rst)
      done |=> !done);

   // A new request only after an idle cycle or the done cycle
   a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst)
      accept |-> !$past(busy) || $past(done));

   // Fixed latency from acceptance to the done cycle
   a_done_latency: assert property (@(posedge clk) disable iff (!rst)
      accept |-> ##(`MEM_WAIT_CYCLES + 4) done);

endmodule

// File: logic/dual_port_ram.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module dual_port_ram (
   input  logic            clk,
   input  logic            rst,
   input  logic            ena,
   input  logic            wea,
   input  mem_pkg::addr_t  addra,
   input  mem_pkg::word_t  dina,
   output mem_pkg::word_t  douta,
   input  logic            enb,
   input  logic            web,
   input  mem_pkg::addr_t  addrb,
   input  mem_pkg::word_t  dinb,
   output mem_pkg::word_t  doutb
);

   localparam int DEPTH = 1 << `MEM_ADDR_W;

   mem_pkg::word_t mem [DEPTH];

   //////////////////////////////
   // Write side, both ports
   //////////////////////////////

   // Same-address writes in one cycle are left undefined
   always_ff @(posedge clk) begin
      if (ena && wea) begin
         mem[addra] <= dina;
      end
      if (enb && web) begin
         mem[addrb] <= dinb;
      end
   end

   //////////////////////////////
   // Read registers
   //////////////////////////////

   // Read-first so the old contents come out on a write
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         douta <= '0;
      end else if (ena) begin
         douta <= mem[addra];
      end
   end

   // Holds until the next enabled access on port b
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         doutb <= '0;
      end else if (enb) begin
         doutb <= mem[addrb];
      end
   end

endmodule

// File: logic/data_memory_subsystem.sv
`timescale 1ns/1ps

module data_memory_subsystem (
   input  logic            clk,
   input  logic            rst,
   // Processor port
   input  logic            enable,
   input  logic            write,
   input  mem_pkg::addr_t  addr,
   input  mem_pkg::word_t  wdata,
   output mem_pkg::word_t  rdata,
   output logic            done,
   output logic            busy,
   // MMU port
   input  logic            mmu_en,
   input  logic            mmu_we,
   input  mem_pkg::addr_t  mmu_addr,
   input  mem_pkg::word_t  mmu_wdata,
   output mem_pkg::word_t  mmu_rdata
);

   logic           accept;
   logic           req_write;
   logic           ram_en;
   logic           ram_we;
   mem_pkg::addr_t ram_addr;
   mem_pkg::word_t ram_wdata;
   mem_pkg::word_t ram_rdata;

   request_latch u_latch (
      .clk       (clk),
      .rst       (rst),
      .accept    (accept),
      .write     (write),
      .addr      (addr),
      .wdata     (wdata),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .req_write (req_write)
   );

   access_sequencer u_seq (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .req_write (req_write),
      .ram_rdata (ram_rdata),
      .accept    (accept),
      .busy      (busy),
      .done      (done),
      .rdata     (rdata)
   );

   // Port a serves the processor, port b the MMU
   dual_port_ram u_ram (
      .clk   (clk),
      .rst   (rst),
      .ena   (ram_en),
      .wea   (ram_we),
      .addra (ram_addr),
      .dina  (ram_wdata),
      .douta (ram_rdata),
      .enb   (mmu_en),
      .web   (mmu_we),
      .addrb (mmu_addr),
      .dinb  (mmu_wdata),
      .doutb (mmu_rdata)
   );

endmodule

// File: dv/mem_checker.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_checker (
   input  logic            clk,
   input  logic            rst,
   input  logic            enable,
   input  logic            write,
   input  mem_pkg::addr_t  addr,
   input  mem_pkg::word_t  wdata,
   input  mem_pkg::word_t  rdata,
   input  logic            done,
   input  logic            busy,
   input  logic            mmu_en,
   input  logic            mmu_we,
   input  mem_pkg::addr_t  mmu_addr,
   input  mem_pkg::word_t  mmu_wdata,
   input  mem_pkg::word_t  mmu_rdata,
   input  logic            entry_done,
   input  int              entry_idx,
   input  logic            report,
   output int              error_count
);

   // Done cycle follows edge WAIT+3 after acceptance and is seen at the next edge
   localparam int LAT = `MEM_WAIT_CYCLES + 4;

   mem_pkg::word_t model [1 << `MEM_ADDR_W];
   logic           in_flight = 1'b0;
   int             edge_cnt = 0;
   logic           req_write = 1'b0;
   mem_pkg::addr_t req_addr = '0;
   mem_pkg::word_t req_wdata = '0;
   mem_pkg::word_t exp_rdata = '0;
   mem_pkg::word_t mmu_exp = '0;
   int             errors = 0;
   int             entry_errors = 0;
   int             entries = 0;
   int             failed = 0;

   assign error_count = errors;

   task automatic flag_mismatch(input string sig, input mem_pkg::word_t got,
                                input mem_pkg::word_t exp);
      $display("MISMATCH %s got %h expected %h at %0t", sig, got, exp, $time);
      errors++;
      entry_errors++;
   endtask

   //////////////////////////////
   // Edge by edge prediction
   //////////////////////////////

   always @(posedge clk) begin
      logic           done_exp;
      mem_pkg::word_t rdata_exp;
      if (!rst) begin
         in_flight = 1'b0;
         edge_cnt  = 0;
         mmu_exp   = '0;
      end else begin
         if (in_flight) begin
            edge_cnt = edge_cnt + 1;
         end
         done_exp  = in_flight && (edge_cnt == LAT);
         rdata_exp = (done_exp && !req_write) ? exp_rdata : '0;
         if (done !== done_exp) begin
            flag_mismatch("done", mem_pkg::word_t'(done), mem_pkg::word_t'(done_exp));
         end
         if (busy !== in_flight) begin
            flag_mismatch("busy", mem_pkg::word_t'(busy), mem_pkg::word_t'(in_flight));
         end
         if (rdata !== rdata_exp) begin
            flag_mismatch("rdata", rdata, rdata_exp);
         end
         if (mmu_rdata !== mmu_exp) begin
            flag_mismatch("mmu_rdata", mmu_rdata, mmu_exp);
         end
         // Both ports read before the writes of the same edge
         if (in_flight && edge_cnt == 1 && !req_write) begin
            exp_rdata = model[req_addr];
         end
         if (mmu_en) begin
            mmu_exp = model[mmu_addr];
         end
         if (in_flight && edge_cnt == 1 && req_write) begin
            model[req_addr] = req_wdata;
         end
         if (mmu_en && mmu_we) begin
            model[mmu_addr] = mmu_wdata;
         end
         // Enable while an access runs is dropped
         if (in_flight && edge_cnt == LAT) begin
            in_flight = 1'b0;
         end else if (!in_flight && enable) begin
            in_flight = 1'b1;
            edge_cnt  = 0;
            req_write = write;
            req_addr  = addr;
            req_wdata = wdata;
         end
         if (entry_done) begin
            entries++;
            if (entry_errors != 0) begin
               failed++;
               $display("entry %0d: %0d errors", entry_idx, entry_errors);
            end else begin
               $display("entry %0d: ok", entry_idx);
            end
            entry_errors = 0;
         end
         if (report) begin
            $display("Entries %0d, failed %0d, errors %0d", entries, failed, errors);
         end
      end
   end

endmodule

// File: dv/tb_data_memory.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_data_memory;

   localparam int NUM_ENTRIES  = 24;
   localparam int RESET_CYCLES = 2;
   localparam int LIMIT_CYCLES = NUM_ENTRIES * (`MEM_WAIT_CYCLES + 8) + RESET_CYCLES;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   // BG leaves the access running under the next entries
   // POKE adds a stray write while busy
   typedef enum logic [2:0] {
      P_RD, P_WR, P_RD_BG, P_WR_BG, P_RD_POKE, P_WR_POKE, M_RD, M_WR
   } op_t;

   typedef struct packed {
      op_t            op;
      mem_pkg::addr_t addr;
      mem_pkg::word_t data;
   } entry_t;

   logic           clk = 1'b0;
   logic           rst = 1'b0;
   logic           enable = 1'b0;
   logic           write = 1'b0;
   mem_pkg::addr_t addr = '0;
   mem_pkg::word_t wdata = '0;
   mem_pkg::word_t rdata;
   logic           done;
   logic           busy;
   logic           mmu_en = 1'b0;
   logic           mmu_we = 1'b0;
   mem_pkg::addr_t mmu_addr = '0;
   mem_pkg::word_t mmu_wdata = '0;
   mem_pkg::word_t mmu_rdata;
   logic           entry_done = 1'b0;
   int             entry_idx = 0;
   logic           report = 1'b0;
   int             error_count;
   logic [31:0]    lfsr;
   entry_t         tbl [NUM_ENTRIES];

   always #2 clk = ~clk;

   data_memory_subsystem dut (.*);

   mem_checker chk (.*);

   // One LFSR step per data bit
   function automatic mem_pkg::word_t next_word();
      mem_pkg::word_t w;
      int             b;
      for (b = 0; b < `MEM_DATA_W; b++) begin
         w[b] = lfsr[0];
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return w;
   endfunction

   task automatic load_table();
      int i;
      tbl[0]  = '{P_WR,      10'h010, 64'h0};
      tbl[1]  = '{P_RD,      10'h010, 64'h0};
      tbl[2]  = '{P_WR,      10'h022, 64'h0123_4567_89ab_cdef};
      tbl[3]  = '{P_RD,      10'h022, 64'h0};
      // Across ports in both directions
      tbl[4]  = '{M_WR,      10'h100, 64'h0};
      tbl[5]  = '{P_RD,      10'h100, 64'h0};
      tbl[6]  = '{P_WR,      10'h155, 64'h0};
      tbl[7]  = '{M_RD,      10'h155, 64'h0};
      tbl[8]  = '{P_RD_POKE, 10'h022, 64'h0};
      tbl[9]  = '{P_RD,      10'h022, 64'h0};
      // MMU traffic under a running processor access
      tbl[10] = '{M_WR,      10'h200, 64'h0};
      tbl[11] = '{P_RD_BG,   10'h010, 64'h0};
      tbl[12] = '{M_RD,      10'h200, 64'h0};
      tbl[13] = '{M_WR,      10'h201, 64'h0};
      tbl[14] = '{M_RD,      10'h201, 64'h0};
      tbl[15] = '{P_WR,      10'h3ff, 64'h0};
      tbl[16] = '{P_RD,      10'h3ff, 64'h0};
      tbl[17] = '{P_WR_BG,   10'h300, 64'h0};
      tbl[18] = '{M_RD,      10'h100, 64'h0};
      tbl[19] = '{P_RD,      10'h300, 64'h0};
      tbl[20] = '{M_WR,      10'h010, 64'h0};
      tbl[21] = '{P_RD,      10'h010, 64'h0};
      tbl[22] = '{P_WR_POKE, 10'h155, 64'h0};
      tbl[23] = '{M_RD,      10'h155, 64'h0};
      for (i = 0; i < NUM_ENTRIES; i++) begin
         if (tbl[i].data == '0) begin
            tbl[i].data = next_word();
         end
      end
   endtask

   task automatic proc_access(input entry_t e);
      enable <= 1'b1;
      write  <= e.op inside {P_WR, P_WR_BG, P_WR_POKE};
      addr   <= e.addr;
      wdata  <= e.data;
      @(posedge clk);
      enable <= 1'b0;
      if (e.op inside {P_RD_POKE, P_WR_POKE}) begin
         // Same word, inverted data, while busy
         repeat (2) @(posedge clk);
         enable <= 1'b1;
         write  <= 1'b1;
         wdata  <= ~e.data;
         @(posedge clk);
         enable <= 1'b0;
      end
      if (!(e.op inside {P_RD_BG, P_WR_BG})) begin
         @(posedge clk);
         while (!done) begin
            @(posedge clk);
         end
      end
   endtask

   task automatic mmu_access(input entry_t e);
      mmu_en    <= 1'b1;
      mmu_we    <= (e.op == M_WR);
      mmu_addr  <= e.addr;
      mmu_wdata <= e.data;
      @(posedge clk);
      mmu_en <= 1'b0;
      mmu_we <= 1'b0;
      // Read word shows up at the next edge
      if (e.op == M_RD) begin
         @(posedge clk);
      end
   endtask

   initial begin
      int i;
      lfsr = 32'd85913;
      load_table();
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b1;
      // Idle cycles so the reset values get checked
      repeat (3) @(posedge clk);
      for (i = 0; i < NUM_ENTRIES; i++) begin
         if (tbl[i].op inside {M_RD, M_WR}) begin
            mmu_access(tbl[i]);
         end else begin
            while (busy) begin
               @(posedge clk);
            end
            proc_access(tbl[i]);
         end
         entry_idx  <= i;
         entry_done <= 1'b1;
         @(posedge clk);
         entry_done <= 1'b0;
      end
      while (busy) begin
         @(posedge clk);
      end
      report <= 1'b1;
      @(posedge clk);
      report <= 1'b0;
      // Error count is settled between edges
      @(negedge clk);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      #(LIMIT_CYCLES * 4);
      $display("Watchdog expired after %0d cycles, the run did not complete", LIMIT_CYCLES);
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: files.f
+incdir+logic
logic/mem_pkg.sv
logic/request_latch.sv
logic/access_sequencer.sv
logic/dual_port_ram.sv
logic/data_memory_subsystem.sv
dv/mem_checker.sv
dv/tb_data_memory.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_data_memory
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP OBJ_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: no result line in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
